/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) cpu_settings.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) cpu_input.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] load_data,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] address,
	output logic [`XLEN-1:0] store_data,
	output logic             mem_load,
	output logic             mem_store
);

	logic             stall;
	logic             redirect;
	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] id_pc;
	logic [`XLEN-1:0] id_inst;
	logic             wb_en;
	logic [4:0]       wb_rd;
	logic [`XLEN-1:0] wb_data;

	id_ex_if  dx ();
	ex_res_if xr ();

	fetch_unit fetch_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.stall    (stall),
		.redirect (redirect),
		.target   (target),
		.inst     (inst),
		.pc       (pc),
		.id_pc    (id_pc),
		.id_inst  (id_inst)
	);

	decode_stage decode_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.id_pc    (id_pc),
		.id_inst  (id_inst),
		.redirect (redirect),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.stall    (stall),
		.dx       (dx.source)
	);

	execute_stage execute_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.dx       (dx.sink),
		.wb_en    (wb_en),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.redirect (redirect),
		.target   (target),
		.xr       (xr.source)
	);

	result_stage result_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.xr         (xr.sink),
		.load_data  (load_data),
		.address    (address),
		.store_data (store_data),
		.mem_load   (mem_load),
		.mem_store  (mem_store),
		.wb_en      (wb_en),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

endmodule

/* cpu_input.txt */
# P <instruction word in hex>, one per word from address 0
# S <store address> <store data> in hex, expected stores in program order
P 123450b7  # lui  x1, 0x12345
P 67808093  # addi x1, x1, 0x678
P ffd00113  # addi x2, x0, -3
P 402081b3  # sub  x3, x1, x2
P 40115213  # srai x4, x2, 1
P 0041c2b3  # xor  x5, x3, x4
P 04502023  # sw   x5, 0x40(x0)
P 04002303  # lw   x6, 0x40(x0)
P 004303b3  # add  x7, x6, x4 after load-use stall
P 04702223  # sw   x7, 0x44(x0)
P 00112433  # slt  x8, x2, x1
P 00040663  # beq  x8, x0, +12 not taken
P 04802423  # sw   x8, 0x48(x0)
P 00814463  # blt  x2, x8, +8 taken
P 04102623  # sw   x1, 0x4c(x0) flushed
P 008004ef  # jal  x9, +8
P 04202623  # sw   x2, 0x4c(x0) flushed
P 04902623  # sw   x9, 0x4c(x0)
P 0000006f  # jal  x0, 0 self-jump
S 00000040 edcba985
S 00000044 edcba983
S 00000048 00000001
S 0000004c 00000040

/* cpu_pkg.sv */
package cpu_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_LUI    = 7'b0110111
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B	// lui result is the immediate
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// b-format shares this layout with a scrambled immediate
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;	// also holds the jal offset bits
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} instr_u;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       use_pc;			// operand a is pc
		logic       use_imm;		// operand b is imm
		logic       is_branch;
		logic [2:0] branch_cond;	// funct3 of the branch
		logic       is_jump;
		logic       mem_load;
		logic       mem_store;
		logic       reg_write;
	} ex_ctrl_t;

endpackage

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width of the core
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define REG_COUNT 32

`endif

/* decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [`XLEN-1:0] id_pc,
	input  logic [`XLEN-1:0] id_inst,
	input  logic             redirect,
	input  logic             wb_en,
	input  logic [4:0]       wb_rd,
	input  logic [`XLEN-1:0] wb_data,
	output logic             stall,
	id_ex_if.source          dx
);

	instr_u           ir;
	opcode_t          opc;
	ex_ctrl_t         ctrl;
	logic [`XLEN-1:0] imm;
	logic             uses_rs1;
	logic             uses_rs2;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// shared by register and immediate arithmetic
	function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic alt);
		alu_op_t op;
		case (funct3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			3'b111:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	assign ir  = id_inst;
	assign opc = opcode_t'(ir.r.opcode);

	always_comb begin
		ctrl     = '0;
		imm      = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opc)
			OPC_OP: begin
				ctrl.alu_op    = funct_to_alu(ir.r.funct3, ir.r.funct7[5]);
				ctrl.reg_write = 1'b1;
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;
			end
			OPC_OP_IMM: begin
				// only srai has the alternate bit, addi never subtracts
				ctrl.alu_op    = funct_to_alu(ir.i.funct3,
					ir.i.funct3 == 3'b101 && ir.r.funct7[5]);
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = {{(`XLEN-12){ir.i.imm[11]}}, ir.i.imm};
				uses_rs1       = 1'b1;
			end
			OPC_LOAD: begin
				ctrl.use_imm   = 1'b1;		// address = rs1 + imm
				ctrl.mem_load  = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = {{(`XLEN-12){ir.i.imm[11]}}, ir.i.imm};
				uses_rs1       = 1'b1;
			end
			OPC_STORE: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_store = 1'b1;
				imm            = {{(`XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.is_branch   = 1'b1;
				ctrl.branch_cond = ir.s.funct3;
				imm = {{(`XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_lo[0], ir.s.imm_hi[5:0],
					ir.s.imm_lo[4:1], 1'b0};
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OPC_JAL: begin
				ctrl.is_jump   = 1'b1;
				ctrl.use_pc    = 1'b1;		// link = pc + 4 through the alu
				ctrl.reg_write = 1'b1;
				imm = {{(`XLEN-20){ir.u.imm[19]}}, ir.u.imm[7:0], ir.u.imm[8],
					ir.u.imm[18:9], 1'b0};
			end
			OPC_LUI: begin
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = {ir.u.imm, 12'b0};
			end
			default: ;	// unknown opcode decodes as a bubble
		endcase
	end

	// register file, written at the end of write-back
	always_ff @(posedge clock) begin
		if (wb_en && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

	assign rs1_val = (ir.r.rs1 == 5'd0) ? '0 :
		(wb_en && wb_rd == ir.r.rs1) ? wb_data : regs[ir.r.rs1];
	assign rs2_val = (ir.r.rs2 == 5'd0) ? '0 :
		(wb_en && wb_rd == ir.r.rs2) ? wb_data : regs[ir.r.rs2];

	// load in execute feeding this instruction
	assign stall = dx.ctrl.mem_load && dx.rd != 5'd0 &&
		((uses_rs1 && dx.rd == ir.r.rs1) || (uses_rs2 && dx.rd == ir.r.rs2));

	always_ff @(posedge clock) begin
		if (!rst_n || stall || redirect)
			dx.ctrl <= '0;			// bubble into execute
		else
			dx.ctrl <= ctrl;
		dx.pc      <= id_pc;
		dx.rs1     <= ir.r.rs1;
		dx.rs2     <= ir.r.rs2;
		dx.rs1_val <= rs1_val;
		dx.rs2_val <= rs2_val;
		dx.imm     <= imm;
		dx.rd      <= ir.r.rd;
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage import cpu_pkg::*; (
	input  logic             clock,
	input  logic             rst_n,
	id_ex_if.sink            dx,
	input  logic             wb_en,
	input  logic [4:0]       wb_rd,
	input  logic [`XLEN-1:0] wb_data,
	output logic             redirect,
	output logic [`XLEN-1:0] target,
	ex_res_if.source         xr
);

	logic [`XLEN-1:0] fwd_a;
	logic [`XLEN-1:0] fwd_b;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_out;
	logic             cond;

	// memory stage is younger than write-back, so it wins
	assign fwd_a = (dx.rs1 != 5'd0 && xr.reg_write && xr.rd == dx.rs1) ? xr.alu :
		(dx.rs1 != 5'd0 && wb_en && wb_rd == dx.rs1) ? wb_data : dx.rs1_val;
	assign fwd_b = (dx.rs2 != 5'd0 && xr.reg_write && xr.rd == dx.rs2) ? xr.alu :
		(dx.rs2 != 5'd0 && wb_en && wb_rd == dx.rs2) ? wb_data : dx.rs2_val;

	assign op_a = dx.ctrl.use_pc ? dx.pc : fwd_a;
	assign op_b = dx.ctrl.is_jump ? 'd4 :	// jal link
		dx.ctrl.use_imm ? dx.imm : fwd_b;

	always_comb begin
		case (dx.ctrl.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << op_b[4:0];
			ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> op_b[4:0];
			ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// branch compare on the forwarded registers
	always_comb begin
		case (dx.ctrl.branch_cond)
			3'b000:  cond = fwd_a == fwd_b;					// beq
			3'b001:  cond = fwd_a != fwd_b;					// bne
			3'b100:  cond = $signed(fwd_a) < $signed(fwd_b);	// blt
			3'b101:  cond = $signed(fwd_a) >= $signed(fwd_b);	// bge
			default: cond = 1'b0;
		endcase
	end

	assign redirect = dx.ctrl.is_jump || (dx.ctrl.is_branch && cond);
	assign target   = dx.pc + dx.imm;

	// execute to memory register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			xr.reg_write <= 1'b0;
			xr.mem_load  <= 1'b0;
			xr.mem_store <= 1'b0;
		end else begin
			xr.reg_write <= dx.ctrl.reg_write;
			xr.mem_load  <= dx.ctrl.mem_load;
			xr.mem_store <= dx.ctrl.mem_store;
		end
		xr.rd         <= dx.rd;
		xr.alu        <= alu_out;
		xr.store_data <= fwd_b;
	end

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_unit (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             stall,
	input  logic             redirect,
	input  logic [`XLEN-1:0] target,
	input  logic [`XLEN-1:0] inst,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] id_pc,
	output logic [`XLEN-1:0] id_inst
);

	localparam logic [`XLEN-1:0] NOP = 32'h0000_0013;	// addi x0, x0, 0

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= target;			// taken branch or jal
		end else if (!stall) begin
			pc <= pc + 'd4;
		end
	end

	// fetch to decode register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			id_pc   <= `RESET_PC;
			id_inst <= NOP;
		end else if (redirect) begin
			id_inst <= NOP;			// drop the wrong-path fetch
		end else if (!stall) begin
			id_pc   <= pc;
			id_inst <= inst;
		end
	end

endmodule

/* files.f */
+incdir+.
cpu_pkg.sv
pipe_if.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu.sv
tb_cpu.sv

/* pipe_if.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

// decode to execute register
interface id_ex_if import cpu_pkg::*; ();
	logic [`XLEN-1:0] pc;
	logic [4:0]       rs1;
	logic [4:0]       rs2;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] imm;
	logic [4:0]       rd;
	ex_ctrl_t         ctrl;

	modport source (
		output pc, rs1, rs2, rs1_val, rs2_val, imm, rd, ctrl
	);

	modport sink (
		input pc, rs1, rs2, rs1_val, rs2_val, imm, rd, ctrl
	);
endinterface

// execute to memory register
interface ex_res_if ();
	logic [4:0]       rd;
	logic [`XLEN-1:0] alu;			// result or memory address
	logic [`XLEN-1:0] store_data;
	logic             mem_load;
	logic             mem_store;
	logic             reg_write;

	modport source (
		output rd, alu, store_data, mem_load, mem_store, reg_write
	);

	modport sink (
		input rd, alu, store_data, mem_load, mem_store, reg_write
	);
endinterface

/* result_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module result_stage (
	input  logic             clock,
	input  logic             rst_n,
	ex_res_if.sink           xr,
	input  logic [`XLEN-1:0] load_data,
	output logic [`XLEN-1:0] address,
	output logic [`XLEN-1:0] store_data,
	output logic             mem_load,
	output logic             mem_store,
	output logic             wb_en,
	output logic [4:0]       wb_rd,
	output logic [`XLEN-1:0] wb_data
);

	logic [`XLEN-1:0] wb_alu;
	logic             wb_load;

	// memory stage drives the data port straight from the register
	assign address    = xr.alu;
	assign store_data = xr.store_data;
	assign mem_load   = xr.mem_load;
	assign mem_store  = xr.mem_store;

	// memory to write-back register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_en   <= 1'b0;
			wb_load <= 1'b0;
		end else begin
			wb_en   <= xr.reg_write;
			wb_load <= xr.mem_load;
		end
		wb_rd  <= xr.rd;
		wb_alu <= xr.alu;
	end

	// load data arrives one cycle after the address
	assign wb_data = wb_load ? load_data : wb_alu;

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

	localparam int IMEM_WORDS    = 64;
	localparam int DMEM_WORDS    = 64;
	localparam int STORE_TIMEOUT = 2000;
	localparam int HALT_TIMEOUT  = 50;
	localparam int HOLD_CYCLES   = 20;

	logic             clock;
	logic             rst_n;
	logic [`XLEN-1:0] inst = 32'h0000_0013;
	logic [`XLEN-1:0] load_data = '0;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] address;
	logic [`XLEN-1:0] store_data;
	logic             mem_load;
	logic             mem_store;

	logic [`XLEN-1:0] imem [IMEM_WORDS];
	logic [`XLEN-1:0] dmem [DMEM_WORDS];
	logic [`XLEN-1:0] exp_addr [$];
	logic [`XLEN-1:0] exp_data [$];
	logic [`XLEN-1:0] next_addr;
	logic [`XLEN-1:0] next_data;
	logic             load_pending = 1'b0;
	logic [`XLEN-1:0] load_addr = '0;
	logic [`XLEN-1:0] halt_pc;
	int               prog_words;
	int               cycles;

	cpu i_cpu (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst       (inst),
		.load_data  (load_data),
		.pc         (pc),
		.address    (address),
		.store_data (store_data),
		.mem_load   (mem_load),
		.mem_store  (mem_store)
	);

	always #4 clock = ~clock;	// 8 ns period

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
			input logic [`XLEN-1:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("** Error: %s is 0x%08h, expected 0x%08h",
				name, actual, expected));
	endtask

	function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
		if ((addr >> 2) < IMEM_WORDS)
			return imem[addr[7:2]];
		return 32'h0000_0013;
	endfunction

	// P lines fill the program, S lines queue the expected stores
	task automatic load_input();
		int               fd;
		int               n;
		string            tok;
		string            rest;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] d;
		fd = $fopen("cpu_input.txt", "r");
		if (fd == 0)
			stop_with_failure("could not open cpu_input.txt");
		prog_words = 0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "P") begin
				n = $fscanf(fd, "%h", a);
				if (n != 1 || prog_words >= IMEM_WORDS)
					stop_with_failure("bad or too many program lines in cpu_input.txt");
				imem[prog_words] = a;
				prog_words++;
			end else if (tok == "S") begin
				n = $fscanf(fd, "%h %h", a, d);
				if (n != 2)
					stop_with_failure("bad store line in cpu_input.txt");
				exp_addr.push_back(a);
				exp_data.push_back(d);
			end else if (tok.getc(0) == "#") begin
				n = $fgets(rest, fd);	// rest of a comment
			end else begin
				stop_with_failure({"unknown line type in cpu_input.txt: ", tok});
			end
		end
		$fclose(fd);
		if (prog_words == 0 || exp_addr.size() == 0)
			stop_with_failure("cpu_input.txt holds no program or no expected stores");
	endtask

	// memory model driven on the falling edge
	always @(negedge clock) begin
		inst = fetch_word(pc);
		if (load_pending)
			load_data = dmem[load_addr[7:2]];	// one cycle after the address
		load_pending = rst_n && mem_load;
		load_addr = address;
		if (rst_n && mem_store) begin
			if (exp_addr.size() == 0)
				stop_with_failure("a store appeared after the last expected one");
			next_addr = exp_addr.pop_front();
			next_data = exp_data.pop_front();
			check_value("address", address, next_addr);
			check_value("store_data", store_data, next_data);
			dmem[address[7:2]] = store_data;
		end
	end

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = {i[11:0], 20'h00013};	// addi x0, x0, i
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = 32'hd0d0_0000 ^ (i * 4);
		load_input();
		halt_pc = 32'((prog_words - 1) * 4);	// last word is the self-jump

		repeat (2) @(posedge clock);
		@(negedge clock);
		// state right out of reset
		check_value("pc", pc, `RESET_PC);
		check_value("mem_load", mem_load, 1'b0);
		check_value("mem_store", mem_store, 1'b0);
		rst_n = 1'b1;

		cycles = 0;
		while (exp_addr.size() != 0) begin
			@(negedge clock);
			cycles++;
			if (cycles > STORE_TIMEOUT)
				stop_with_failure($sformatf("timeout, %0d expected stores never appeared",
					exp_addr.size()));
		end

		cycles = 0;
		while (pc !== halt_pc) begin
			@(negedge clock);
			cycles++;
			if (cycles > HALT_TIMEOUT)
				stop_with_failure("pc never reached the final self-jump");
		end

		// jump refetched every third cycle with two flushed fetches between
		for (int k = 0; k < HOLD_CYCLES; k++) begin
			check_value("pc", pc, halt_pc + 32'(4 * (k % 3)));
			@(negedge clock);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
